/* common/agu_pkg.sv */
package agu_pkg;

  localparam int VADDR_W     = 44;
  localparam int PAGE_BITS   = 13;
  localparam int LINE_BITS   = 7;
  localparam int VPN_W       = 31;
  localparam int PPN_W       = 31;
  localparam int BANK_COUNT  = 32;
  localparam int BANK_W      = 5;
  localparam int TLB_ENTRIES = 16;
  localparam int TLB_IDX_W   = 4;
  localparam int REG_NO_W    = 9;
  localparam int PAIR_ADDR_W = 36;

  // size opcodes, same numbering as the load/store unit
  typedef enum logic [4:0] {
    sz_int128_u      = 5'd0,
    sz_dbl128_u      = 5'd1,
    sz_sgl128_u      = 5'd2,
    sz_long_double   = 5'd3,
    sz_single_e      = 5'd4,
    sz_single        = 5'd5,
    sz_single_d      = 5'd6,
    sz_int64_a       = 5'd7,
    sz_double_e      = 5'd8,
    sz_double        = 5'd9,
    sz_single_pair_d = 5'd10,
    sz_int64_b       = 5'd11,
    sz_int128_a      = 5'd12,
    sz_dbl128_a      = 5'd13,
    sz_sgl128_a      = 5'd14,
    sz_fill_spill    = 5'd15,
    sz_byte          = 5'd16,
    sz_half          = 5'd17,
    sz_word          = 5'd18,
    sz_dword         = 5'd19
  } size_code_e;

  // access length in bytes
  typedef enum logic [2:0] {
    b1, b2, b4, b8, b10, b16, b20
  } size_class_e;

  typedef struct packed {
    logic [VADDR_W-1:0]  va;
    size_code_e          size;
    logic                split;
    logic                store;
    logic                kernel;
    logic [REG_NO_W-1:0] reg_no;
  } mem_op_t;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic             sys;
    logic             present;
  } tlb_entry_t;

  typedef struct packed {
    logic             valid;
    logic [VPN_W-1:0] vpn;
    tlb_entry_t       entry;
  } tlb_fill_t;

  typedef struct packed {
    logic [PAIR_ADDR_W-1:0] addr_even;
    logic [PAIR_ADDR_W-1:0] addr_odd;
    logic                   odd;
    logic [1:0]             addr_low;
    logic [BANK_COUNT-1:0]  banks;
    logic                   store;
    logic [REG_NO_W-1:0]    reg_no;
    logic                   fault;
    // bit 1 privilege, bit 0 not present
    logic [1:0]             fault_code;
  } agu_result_t;

endpackage

/* dtlb/dtlb_array.sv */
module dtlb_array
  import agu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  tlb_fill_t        fill,
  input  logic [VPN_W-1:0] main_vpn,
  input  logic [VPN_W-1:0] next_vpn,
  output logic             main_hit,
  output tlb_entry_t       main_entry,
  output logic             next_hit,
  output tlb_entry_t       next_entry
);

  localparam int TAG_W = VPN_W - TLB_IDX_W;

  logic [TLB_ENTRIES-1:0] valid;
  logic [TAG_W-1:0]       tag   [TLB_ENTRIES];
  tlb_entry_t             entry [TLB_ENTRIES];

  logic [TLB_IDX_W-1:0] fill_idx;
  logic [TLB_IDX_W-1:0] main_idx;
  logic [TLB_IDX_W-1:0] next_idx;

  assign fill_idx = fill.vpn[TLB_IDX_W-1:0];
  assign main_idx = main_vpn[TLB_IDX_W-1:0];
  assign next_idx = next_vpn[TLB_IDX_W-1:0];

  // direct mapped, low vpn bits pick the slot
  assign main_hit   = valid[main_idx] & (tag[main_idx] == main_vpn[VPN_W-1:TLB_IDX_W]);
  assign main_entry = entry[main_idx];
  assign next_hit   = valid[next_idx] & (tag[next_idx] == next_vpn[VPN_W-1:TLB_IDX_W]);
  assign next_entry = entry[next_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill.valid) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill.valid) begin
      tag[fill_idx]   <= fill.vpn[VPN_W-1:TLB_IDX_W];
      entry[fill_idx] <= fill.entry;
    end
  end

endmodule

/* agu/agu_bank_mask.sv */
module agu_bank_mask
  import agu_pkg::*;
(
  input  size_code_e            size,
  input  logic [6:0]            va_low,
  output logic [BANK_COUNT-1:0] banks
);

  size_class_e             cls;
  logic [BANK_W-1:0]       bank0;
  logic                    step_over;
  logic                    step_over2;
  logic [5:0]              span;
  logic [2*BANK_COUNT-1:0] rot;

  always_comb begin
    case (size)
      sz_byte:                               cls = b1;
      sz_half:                               cls = b2;
      sz_word, sz_single_e, sz_single,
      sz_single_d:                           cls = b4;
      sz_long_double:                        cls = b10;
      sz_int128_u, sz_dbl128_u, sz_sgl128_u,
      sz_int128_a, sz_dbl128_a, sz_sgl128_a: cls = b16;
      sz_fill_spill:                         cls = b20;
      // dword, the 64-bit codes and anything unknown
      default:                               cls = b8;
    endcase
  end

  assign bank0      = va_low[6:2];
  assign step_over  = |va_low[1:0];
  assign step_over2 = &va_low[1:0];

  // span bit k set when bank0+k is touched
  always_comb begin
    span[0] = 1'b1;
    span[1] = (cls inside {b8, b10, b16, b20}) | (step_over & (cls == b4)) |
              (step_over2 & (cls == b2));
    span[2] = (step_over & (cls == b8)) | (cls inside {b10, b16, b20});
    span[3] = (step_over2 & (cls == b10)) | (cls inside {b16, b20});
    span[4] = (step_over & (cls == b16)) | (cls == b20);
    span[5] = step_over & (cls == b20);
  end

  // rotate left by bank0, wrapping past bank 31
  assign rot   = {{(2*BANK_COUNT-6){1'b0}}, span} << bank0;
  assign banks = rot[BANK_COUNT-1:0] | rot[2*BANK_COUNT-1:BANK_COUNT];

endmodule

/* agu/agu_capture.sv */
module agu_capture
  import agu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  mem_op_t in_op,
  input  logic    rs_stall,
  input  logic    miss,
  output logic    busy,
  output logic    cap_valid,
  output mem_op_t cap_op
);

  logic load_op;

  // miss already qualified by cap_valid in the translate stage
  assign busy = miss | rs_stall;

  assign load_op = ~busy & in_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      cap_valid <= 1'b0;
    end else if (~busy) begin
      // empty slot when nothing arrives
      cap_valid <= in_valid;
    end
  end

  // payload only, held while busy
  always_ff @(posedge clk) begin
    if (load_op) begin
      cap_op <= in_op;
    end
  end

endmodule

/* agu/agu_translate.sv */
module agu_translate
  import agu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             cap_valid,
  input  mem_op_t          cap_op,
  input  logic             rs_stall,
  output logic [VPN_W-1:0] main_vpn,
  output logic [VPN_W-1:0] next_vpn,
  input  logic             main_hit,
  input  tlb_entry_t       main_entry,
  input  logic             next_hit,
  input  tlb_entry_t       next_entry,
  output logic             miss,
  output logic             out_valid,
  output agu_result_t      out
);

  localparam int LINE_IDX_W = PAGE_BITS - LINE_BITS;

  logic [LINE_IDX_W:0]    line_sum;
  logic [LINE_IDX_W-1:0]  next_line;
  logic                   page_carry;
  logic                   use_next;
  logic [PPN_W-1:0]       next_ppn;
  logic [PAIR_ADDR_W-1:0] cur_pair;
  logic [PAIR_ADDR_W-1:0] nxt_pair;
  logic [1:0]             fault_code;
  logic [BANK_COUNT-1:0]  banks;
  logic                   take;
  agu_result_t            res;

  assign main_vpn = cap_op.va[VADDR_W-1:PAGE_BITS];
  assign next_vpn = main_vpn + 1'b1;

  // next line within the page, carry means it lands in the next page
  assign line_sum   = {1'b0, cap_op.va[PAGE_BITS-1:LINE_BITS]} + 1'b1;
  assign next_line  = line_sum[LINE_IDX_W-1:0];
  assign page_carry = line_sum[LINE_IDX_W];

  // second page only matters for split ops crossing the page
  assign use_next = cap_op.split & page_carry;
  assign next_ppn = use_next ? next_entry.ppn : main_entry.ppn;

  assign cur_pair = {main_entry.ppn, cap_op.va[PAGE_BITS-1:LINE_BITS+1]};
  assign nxt_pair = {next_ppn, next_line[LINE_IDX_W-1:1]};

  assign miss = cap_valid & (~main_hit | (use_next & ~next_hit));

  assign fault_code[1] = ~cap_op.kernel & (main_entry.sys | (use_next & next_entry.sys));
  assign fault_code[0] = ~main_entry.present | (use_next & ~next_entry.present);

  agu_bank_mask u_bank_mask (
    .size   (cap_op.size),
    .va_low (cap_op.va[LINE_BITS-1:0]),
    .banks  (banks)
  );

  always_comb begin
    res = '0;
    // line with bit 7 clear is the even half of the pair
    if (cap_op.va[LINE_BITS]) begin
      res.addr_even = nxt_pair;
      res.addr_odd  = cur_pair;
    end else begin
      res.addr_even = cur_pair;
      res.addr_odd  = nxt_pair;
    end
    res.odd        = cap_op.va[LINE_BITS];
    res.addr_low   = cap_op.va[1:0];
    res.banks      = banks;
    res.store      = cap_op.store;
    res.reg_no     = cap_op.reg_no;
    res.fault      = |fault_code;
    res.fault_code = fault_code;
  end

  assign take = cap_valid & ~miss;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (~rs_stall) begin
      out_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (~rs_stall & take) begin
      out <= res;
    end
  end

endmodule

/* design/agu_top.sv */
module agu_top
  import agu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  mem_op_t     in_op,
  input  tlb_fill_t   fill,
  input  logic        rs_stall,
  output logic        busy,
  output logic        out_valid,
  output agu_result_t out
);

  logic             cap_valid;
  mem_op_t          cap_op;
  logic             miss;
  logic [VPN_W-1:0] main_vpn;
  logic [VPN_W-1:0] next_vpn;
  logic             main_hit;
  logic             next_hit;
  tlb_entry_t       main_entry;
  tlb_entry_t       next_entry;

  agu_capture u_capture (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .rs_stall  (rs_stall),
    .miss      (miss),
    .busy      (busy),
    .cap_valid (cap_valid),
    .cap_op    (cap_op)
  );

  dtlb_array u_dtlb (
    .clk        (clk),
    .rst        (rst),
    .fill       (fill),
    .main_vpn   (main_vpn),
    .next_vpn   (next_vpn),
    .main_hit   (main_hit),
    .main_entry (main_entry),
    .next_hit   (next_hit),
    .next_entry (next_entry)
  );

  agu_translate u_translate (
    .clk        (clk),
    .rst        (rst),
    .cap_valid  (cap_valid),
    .cap_op     (cap_op),
    .rs_stall   (rs_stall),
    .main_vpn   (main_vpn),
    .next_vpn   (next_vpn),
    .main_hit   (main_hit),
    .main_entry (main_entry),
    .next_hit   (next_hit),
    .next_entry (next_entry),
    .miss       (miss),
    .out_valid  (out_valid),
    .out        (out)
  );

endmodule

/* verification/agu_tb.sv */
module agu_tb
  import agu_pkg::*;
();

  typedef struct packed {
    mem_op_t     op;
    tlb_fill_t   fill;
    logic        fill_first;
    logic [1:0]  stall;
    logic        exp_miss;
    agu_result_t exp;
  } row_t;

  localparam tlb_fill_t NO_FILL = '0;

  logic        clk;
  logic        rst;
  logic        in_valid;
  mem_op_t     in_op;
  tlb_fill_t   fill;
  logic        rs_stall;
  logic        busy;
  logic        out_valid;
  agu_result_t out;

  row_t             rows[$];
  logic [31:0]      rng;
  int               cycles = 0;
  int               cycle_limit = 100;
  logic             sh_valid [TLB_ENTRIES];
  logic [VPN_W-1:0] sh_vpn   [TLB_ENTRIES];
  tlb_entry_t       sh_entry [TLB_ENTRIES];

  agu_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .fill      (fill),
    .rs_stall  (rs_stall),
    .busy      (busy),
    .out_valid (out_valid),
    .out       (out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles, the DUT never finished the table", cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic shadow_hit(input logic [VPN_W-1:0] vpn);
    return sh_valid[vpn[TLB_IDX_W-1:0]] && (sh_vpn[vpn[TLB_IDX_W-1:0]] == vpn);
  endfunction

  // byte count of each size code
  function automatic int class_bytes(input size_code_e size);
    case (int'(size))
      16: return 1;
      17: return 2;
      18, 4, 5, 6: return 4;
      3: return 10;
      0, 1, 2, 12, 13, 14: return 16;
      15: return 20;
      default: return 8;
    endcase
  endfunction

  function automatic logic model_miss(input mem_op_t op);
    logic [VPN_W-1:0] vpn;
    logic             use_next;
    vpn = op.va[VADDR_W-1:PAGE_BITS];
    use_next = op.split && (&op.va[12:7]);
    return !shadow_hit(vpn) || (use_next && !shadow_hit(vpn + 31'd1));
  endfunction

  function automatic agu_result_t model_result(input mem_op_t op);
    agu_result_t            r;
    logic [VPN_W-1:0]       nvpn;
    logic [5:0]             nxt_line;
    logic                   use_next;
    tlb_entry_t             m;
    tlb_entry_t             n;
    logic [PAIR_ADDR_W-1:0] cur_pair;
    logic [PAIR_ADDR_W-1:0] nxt_pair;
    int                     cnt;
    nvpn = op.va[VADDR_W-1:PAGE_BITS] + 31'd1;
    nxt_line = op.va[12:7] + 6'd1;
    use_next = op.split && (op.va[12:7] == 6'h3f);
    m = sh_entry[op.va[PAGE_BITS+TLB_IDX_W-1:PAGE_BITS]];
    n = sh_entry[nvpn[TLB_IDX_W-1:0]];
    cur_pair = {m.ppn, op.va[12:8]};
    nxt_pair = {(use_next ? n.ppn : m.ppn), nxt_line[5:1]};
    r = '0;
    r.odd = op.va[7];
    r.addr_even = op.va[7] ? nxt_pair : cur_pair;
    r.addr_odd = op.va[7] ? cur_pair : nxt_pair;
    r.addr_low = op.va[1:0];
    // n banks from bank0 wrapping past 31
    cnt = (int'(op.va[1:0]) + class_bytes(op.size) + 3) / 4;
    for (int k = 0; k < cnt; k++) begin
      r.banks[(int'(op.va[6:2]) + k) % BANK_COUNT] = 1'b1;
    end
    r.store = op.store;
    r.reg_no = op.reg_no;
    r.fault_code[1] = !op.kernel && (m.sys || (use_next && n.sys));
    r.fault_code[0] = !m.present || (use_next && !n.present);
    r.fault = |r.fault_code;
    return r;
  endfunction

  // flags are split, store, kernel
  function automatic mem_op_t mk_op(input logic [VADDR_W-1:0] va, input size_code_e size,
                                    input logic [2:0] flags);
    mem_op_t op;
    op = '0;
    op.va = va;
    op.size = size;
    {op.split, op.store, op.kernel} = flags;
    return op;
  endfunction

  function automatic tlb_fill_t mk_fill(input logic [VPN_W-1:0] vpn,
                                        input logic [PPN_W-1:0] ppn, input logic [1:0] sys_pres);
    tlb_fill_t f;
    f.valid = 1'b1;
    f.vpn = vpn;
    f.entry.ppn = ppn;
    {f.entry.sys, f.entry.present} = sys_pres;
    return f;
  endfunction

  task automatic add_row(input mem_op_t op, input tlb_fill_t f, input logic first,
                         input logic [1:0] stall);
    row_t r;
    r.op = op;
    r.op.reg_no = REG_NO_W'(rows.size());
    r.fill = f;
    r.fill_first = first;
    r.stall = stall;
    if (first && f.valid) begin
      sh_valid[f.vpn[TLB_IDX_W-1:0]] = 1'b1;
      sh_vpn[f.vpn[TLB_IDX_W-1:0]] = f.vpn;
      sh_entry[f.vpn[TLB_IDX_W-1:0]] = f.entry;
    end
    r.exp_miss = model_miss(r.op);
    // a late fill lands while the op waits in capture
    if (!first && f.valid) begin
      sh_valid[f.vpn[TLB_IDX_W-1:0]] = 1'b1;
      sh_vpn[f.vpn[TLB_IDX_W-1:0]] = f.vpn;
      sh_entry[f.vpn[TLB_IDX_W-1:0]] = f.entry;
    end
    r.exp = model_result(r.op);
    rows.push_back(r);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    $display("TEST FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) report_mismatch(what, 64'(got), 64'(exp));
  endtask

  task automatic check_result(input agu_result_t got, input agu_result_t exp);
    if (got.addr_even !== exp.addr_even)
      report_mismatch("addr_even", got.addr_even, exp.addr_even);
    if (got.addr_odd !== exp.addr_odd) report_mismatch("addr_odd", got.addr_odd, exp.addr_odd);
    if (got.odd !== exp.odd) report_mismatch("odd", 64'(got.odd), 64'(exp.odd));
    if (got.addr_low !== exp.addr_low) report_mismatch("addr_low", got.addr_low, exp.addr_low);
    if (got.banks !== exp.banks) report_mismatch("banks", got.banks, exp.banks);
    if (got.store !== exp.store) report_mismatch("store", 64'(got.store), 64'(exp.store));
    if (got.reg_no !== exp.reg_no) report_mismatch("reg_no", got.reg_no, exp.reg_no);
    if (got.fault !== exp.fault) report_mismatch("fault", 64'(got.fault), 64'(exp.fault));
    if (got.fault_code !== exp.fault_code)
      report_mismatch("fault_code", got.fault_code, exp.fault_code);
  endtask

  task automatic build_table();
    logic [31:0] r1;
    logic [31:0] r2;
    // mapped pages, carries, misses, faults
    add_row(mk_op({31'h1234, 13'h00a5}, sz_word, 3'b011), mk_fill(31'h1234, 31'h0abcde1, 2'b01),
            1'b1, 2'd0);
    add_row(mk_op({31'h1234, 13'h1fb6}, sz_dword, 3'b101), mk_fill(31'h1235, 31'h13579bd, 2'b01),
            1'b1, 2'd0);
    add_row(mk_op({31'h1234, 13'h1fb6}, sz_dword, 3'b001), NO_FILL, 1'b0, 2'd2);
    add_row(mk_op({31'h700d, 13'h1fc3}, sz_long_double, 3'b011),
            mk_fill(31'h700d, 31'h02468ac, 2'b01), 1'b1, 2'd0);
    add_row(mk_op({31'h500a, 13'h0123}, sz_half, 3'b001), mk_fill(31'h500a, 31'h0fedcba, 2'b01),
            1'b0, 2'd1);
    add_row(mk_op({31'h600b, 13'h0040}, sz_byte, 3'b001), mk_fill(31'h600b, 31'h0111222, 2'b01),
            1'b1, 2'd0);
    add_row(mk_op({31'h600b, 13'h1fe1}, sz_fill_spill, 3'b111),
            mk_fill(31'h600c, 31'h0333444, 2'b01), 1'b0, 2'd0);
    add_row(mk_op({31'h2000, 13'h0100}, sz_word, 3'b000), mk_fill(31'h2000, 31'h0555666, 2'b11),
            1'b1, 2'd0);
    add_row(mk_op({31'h2000, 13'h0104}, sz_word, 3'b001), NO_FILL, 1'b0, 2'd0);
    add_row(mk_op({31'h2001, 13'h0200}, sz_dword, 3'b001), mk_fill(31'h2001, 31'h0777888, 2'b00),
            1'b1, 2'd0);
    add_row(mk_op({31'h3006, 13'h0208}, sz_single, 3'b000), mk_fill(31'h3006, 31'h0999aaa, 2'b01),
            1'b1, 2'd0);
    add_row(mk_op({31'h3006, 13'h1f8c}, sz_int128_u, 3'b100),
            mk_fill(31'h3007, 31'h0bbbccc, 2'b11), 1'b1, 2'd0);
    add_row(mk_op({31'h3006, 13'h1f8c}, sz_int128_u, 3'b000), NO_FILL, 1'b0, 2'd3);
    // split without a carry ignores the sys next page
    add_row(mk_op({31'h3006, 13'h0208}, sz_single, 3'b100), NO_FILL, 1'b0, 2'd0);
    add_row(mk_op({31'h4008, 13'h0abc}, sz_double, 3'b011), mk_fill(31'h4008, 31'h0dddeee, 2'b01),
            1'b1, 2'd0);
    add_row(mk_op({31'h4008, 13'h1ff0}, sz_dbl128_a, 3'b101),
            mk_fill(31'h4009, 31'h0fff000, 2'b00), 1'b1, 2'd0);
    add_row(mk_op({31'h4008, 13'h1ff0}, sz_dbl128_a, 3'b001), NO_FILL, 1'b0, 2'd1);
    // every size code at every low offset with bank0 near 31 so long spans wrap
    for (int code = 0; code < 20; code++) begin
      for (int lo = 0; lo < 4; lo++) begin
        rng = xorshift(rng);
        add_row(mk_op({31'h1234, rng[5:0], 5'(31 - code % 5), 2'(lo)}, size_code_e'(code),
                      {1'b0, rng[6], 1'b1}), NO_FILL, 1'b0, 2'd0);
      end
    end
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      r1 = rng;
      rng = xorshift(rng);
      r2 = rng;
      add_row(mk_op({31'h1234, r1[12:0]}, size_code_e'(r1[20:16] % 5'd20), r2[4:2]),
              NO_FILL, 1'b0, r2[1:0]);
    end
  endtask

  task automatic apply_row(input row_t r);
    int lat;
    lat = 0;
    if (r.fill_first && r.fill.valid) begin
      fill = r.fill;
      @(negedge clk);
      fill = '0;
    end
    check_level("busy before issue", busy, 1'b0);
    in_op = r.op;
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    in_op = '0;
    check_level("busy after capture", busy, r.exp_miss);
    if (r.exp_miss) begin
      repeat (2) begin
        @(negedge clk);
        check_level("out_valid while missing", out_valid, 1'b0);
        check_level("busy while missing", busy, 1'b1);
      end
    end
    if (!r.fill_first && r.fill.valid) begin
      fill = r.fill;
      @(negedge clk);
      fill = '0;
      check_level("busy after fill", busy, 1'b0);
    end
    // stall while the op sits in capture
    rs_stall = (r.stall != 0);
    repeat (r.stall) begin
      @(negedge clk);
      check_level("out_valid under stall", out_valid, 1'b0);
      check_level("busy under stall", busy, 1'b1);
    end
    rs_stall = 1'b0;
    do begin
      @(negedge clk);
      lat++;
    end while (!out_valid);
    check_level("result one edge after release", lat == 1, 1'b1);
    check_result(out, r.exp);
    // stall while the result sits in the output register
    rs_stall = (r.stall != 0);
    repeat (r.stall) begin
      @(negedge clk);
      check_level("out_valid held", out_valid, 1'b1);
      check_result(out, r.exp);
    end
    rs_stall = 1'b0;
    @(negedge clk);
    check_level("one result per op", out_valid, 1'b0);
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = '0;
    fill = '0;
    rs_stall = 1'b0;
    rng = 32'd60;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      sh_valid[i] = 1'b0;
      sh_vpn[i] = '0;
      sh_entry[i] = '0;
    end
    build_table();
    cycle_limit = 40 * rows.size() + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_level("out_valid after reset", out_valid, 1'b0);
      check_level("busy after reset", busy, 1'b0);
    end
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* sim.f */
common/agu_pkg.sv
dtlb/dtlb_array.sv
agu/agu_bank_mask.sv
agu/agu_capture.sv
agu/agu_translate.sv
design/agu_top.sv
verification/agu_tb.sv

/* run.sh */
#!/bin/sh
# build agu_tb with verilator, run it, then judge the run from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module agu_tb -f sim.f -o agu_sim &&
  ./obj_dir/agu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
